/* msp_mem_macros.svh */
`ifndef MSP_MEM_MACROS_SVH
`define MSP_MEM_MACROS_SVH

// ==========================================================
// Data memory (RAM)
// ==========================================================

// Byte address of first RAM location
`define DMEM_BASE     16'h0200

// RAM size in bytes
`define DMEM_SIZE     512

// Top bit of RAM word address, 256 words
`define DMEM_MSB      7

// ==========================================================
// Program memory (ROM)
// ==========================================================

// ROM size in bytes, region ends at 0xFFFF
`define PMEM_SIZE     2048

// First ROM byte address, top of the 64k space minus size
`define PMEM_BASE     (17'h1_0000 - `PMEM_SIZE)

// Top bit of ROM word address, 1k words
`define PMEM_MSB      9

// ==========================================================
// Peripheral register block
// ==========================================================

// Peripheral word address of register 0
`define PER_REG_BASE  8'h08

// Register count in the block
`define PER_REG_NUM   8

`endif

/* msp_mem_pkg.sv */
package msp_mem_pkg;

  // ==========================================================
  // Basic bus types
  // ==========================================================

  typedef logic [15:0] word_t;     // Data word
  typedef logic [14:0] wadr_t;     // Word address on core bus
  typedef logic [1:0]  bwe_t;      // Byte mask, bit 1 = high byte
  typedef logic [7:0]  per_adr_t;  // Peripheral word address

  // Read data source, registered in the request cycle
  typedef enum logic [1:0] {
    SRC_DMEM = 2'd0,               // RAM, also unmapped space
    SRC_PER  = 2'd1,               // Peripheral register
    SRC_PMEM = 2'd2                // ROM
  } rd_src_t;

  // ==========================================================
  // Master requests
  // ==========================================================

  typedef struct packed {
    logic  en;                     // Bus enable, one cycle
    bwe_t  wr;                     // Nonzero means write
    wadr_t mab;                    // Word address
    word_t dout;                   // Write data
  } eu_req_t;

  typedef struct packed {
    logic  en;                     // Fetch enable
    wadr_t mab;                    // Fetch word address
  } fe_req_t;

  typedef struct packed {
    logic        en;               // Debug access enable
    bwe_t        wr;               // Nonzero means write
    logic [15:0] addr;             // Byte address
    word_t       dout;             // Write data
  } dbg_req_t;

  // Request to the peripheral bus
  typedef struct packed {
    logic     en;                  // Access enable
    bwe_t     wen;                 // Byte writes, active high
    per_adr_t addr;                // Peripheral word address
    word_t    din;                 // Write data
  } per_req_t;

endpackage

/* per_regs.sv */
`include "msp_mem_macros.svh"

module per_regs (
  input  logic                  mclk,      // Main clock
  input  logic                  puc,       // System reset
  input  msp_mem_pkg::per_req_t per_req,   // Peripheral bus request
  output msp_mem_pkg::word_t    per_dout   // Read data, zero when not hit
);
  import msp_mem_pkg::*;

  localparam int unsigned REG_AW = $clog2(`PER_REG_NUM);

  word_t             regs_q [`PER_REG_NUM];  // Settings registers
  per_adr_t          reg_off;                // Offset from block base
  logic              reg_hit;                // Access inside this block
  logic [REG_AW-1:0] reg_idx;

  // ==========================================================
  // Address decode
  // ==========================================================
  assign reg_off = per_req.addr - per_adr_t'(`PER_REG_BASE);
  assign reg_hit = per_req.en & (reg_off < per_adr_t'(`PER_REG_NUM));
  assign reg_idx = reg_off[REG_AW-1:0];

  // ==========================================================
  // Register writes per byte lane
  // ==========================================================
  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      for (int i = 0; i < `PER_REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (reg_hit) begin
      if (per_req.wen[0]) begin
        regs_q[reg_idx][7:0] <= per_req.din[7:0];
      end
      if (per_req.wen[1]) begin
        regs_q[reg_idx][15:8] <= per_req.din[15:8];
      end
    end
  end

  // Zero when idle, so outputs of several blocks can be ORed
  assign per_dout = reg_hit ? regs_q[reg_idx] : '0;

endmodule

/* pmem_rom.sv */
`include "msp_mem_macros.svh"

module pmem_rom (
  input  logic               mclk,   // Main clock
  input  logic               cen,    // Chip enable, active low
  input  msp_mem_pkg::bwe_t  wen,    // Byte writes, active low
  input  logic [`PMEM_MSB:0] addr,   // Word address
  input  msp_mem_pkg::word_t din,    // Write data
  output msp_mem_pkg::word_t dout    // Read data, one cycle latency
);
  import msp_mem_pkg::*;

  localparam int unsigned DEPTH = 1 << (`PMEM_MSB + 1);

  // Program image starts blank, loaded through debug
  word_t mem [DEPTH] = '{default: '0};
  word_t wr_word;                    // Old word merged with new lanes

  // Keep lanes whose enable is inactive
  assign wr_word = {wen[1] ? mem[addr][15:8] : din[15:8],
                    wen[0] ? mem[addr][7:0]  : din[7:0]};

  always_ff @(posedge mclk) begin
    if (!cen) begin
      if (wen != 2'b11) begin
        mem[addr] <= wr_word;
      end
      dout <= mem[addr];             // Old data during a write
    end
  end

endmodule

/* dmem_ram.sv */
`include "msp_mem_macros.svh"

module dmem_ram (
  input  logic               mclk,   // Main clock
  input  logic               cen,    // Chip enable, active low
  input  msp_mem_pkg::bwe_t  wen,    // Byte writes, active low
  input  logic [`DMEM_MSB:0] addr,   // Word address
  input  msp_mem_pkg::word_t din,    // Write data
  output msp_mem_pkg::word_t dout    // Read data, one cycle latency
);
  import msp_mem_pkg::*;

  localparam int unsigned DEPTH = 1 << (`DMEM_MSB + 1);

  word_t mem [DEPTH];                // 256 words

  // ==========================================================
  // Byte lane writes, registered read
  // ==========================================================
  always_ff @(posedge mclk) begin
    if (!cen) begin
      if (!wen[0]) begin
        mem[addr][7:0] <= din[7:0];    // Low byte lane
      end
      if (!wen[1]) begin
        mem[addr][15:8] <= din[15:8];  // High byte lane
      end
      dout <= mem[addr];
    end
    // Output holds while disabled
  end

endmodule

/* mem_backbone.sv */
`include "msp_mem_macros.svh"

module mem_backbone (
  input  logic                  mclk,          // Main clock
  input  logic                  puc,           // System reset
  input  msp_mem_pkg::eu_req_t  eu_req,        // Execution unit access
  input  msp_mem_pkg::fe_req_t  fe_req,        // Instruction fetch
  input  msp_mem_pkg::dbg_req_t dbg_req,       // Debug unit access
  input  logic                  dbg_halt_st,   // CPU halted by debug
  input  msp_mem_pkg::word_t    pmem_dout,     // ROM read data
  input  msp_mem_pkg::word_t    dmem_dout,     // RAM read data
  input  msp_mem_pkg::word_t    per_dout,      // Peripheral read data, comb
  output msp_mem_pkg::word_t    eu_mdb_in,     // Execution unit read data
  output msp_mem_pkg::word_t    fe_mdb_in,     // Fetched instruction word
  output msp_mem_pkg::word_t    dbg_mem_din,   // Debug read data
  output logic                  fe_pmem_wait,  // Fetch stalled by EU
  output logic                  pmem_cen,      // ROM enable, active low
  output msp_mem_pkg::bwe_t     pmem_wen,      // ROM byte writes, active low
  output logic [`PMEM_MSB:0]    pmem_addr,     // ROM word address
  output msp_mem_pkg::word_t    pmem_din,      // ROM write data
  output logic                  dmem_cen,      // RAM enable, active low
  output msp_mem_pkg::bwe_t     dmem_wen,      // RAM byte writes, active low
  output logic [`DMEM_MSB:0]    dmem_addr,     // RAM word address
  output msp_mem_pkg::word_t    dmem_din,      // RAM write data
  output msp_mem_pkg::per_req_t per_req        // Peripheral bus
);
  import msp_mem_pkg::*;

  // Region limits as word addresses
  localparam wadr_t PMEM_WBASE = wadr_t'(`PMEM_BASE >> 1);
  localparam wadr_t DMEM_WBASE = wadr_t'(`DMEM_BASE >> 1);
  localparam wadr_t DMEM_WEND  = wadr_t'((`DMEM_BASE + `DMEM_SIZE) >> 1);

  wadr_t   dbg_wadr;        // Debug address, word aligned
  logic    eu_dmem_sel;
  logic    dbg_dmem_sel;
  wadr_t   eu_dmem_off;
  wadr_t   dbg_dmem_off;
  logic    eu_pmem_sel;     // EU reads only
  logic    fe_pmem_sel;
  logic    dbg_pmem_sel;
  wadr_t   eu_pmem_off;
  wadr_t   fe_pmem_off;
  wadr_t   dbg_pmem_off;
  logic    eu_per_sel;
  logic    dbg_per_sel;
  word_t   per_dout_q;      // Peripheral data, one cycle late
  rd_src_t eu_src_q;        // EU return source
  rd_src_t dbg_src_q;       // Debug return source
  logic    fe_pmem_sel_q;   // Fetch select, last cycle
  logic    fe_save;
  logic    fe_restore;
  word_t   pmem_bckup_q;    // Last fetched word
  logic    bckup_sel_q;     // Frontend sees backup word

  assign dbg_wadr = dbg_req.addr[15:1];

  // ==========================================================
  // RAM decode, debug wins address and data
  // ==========================================================
  assign eu_dmem_sel  = eu_req.en & (eu_req.mab >= DMEM_WBASE) & (eu_req.mab < DMEM_WEND);
  assign dbg_dmem_sel = dbg_req.en & (dbg_wadr >= DMEM_WBASE) & (dbg_wadr < DMEM_WEND);
  assign eu_dmem_off  = eu_req.mab - DMEM_WBASE;
  assign dbg_dmem_off = dbg_wadr - DMEM_WBASE;

  assign dmem_cen  = ~(eu_dmem_sel | dbg_dmem_sel);
  assign dmem_addr = dbg_dmem_sel ? dbg_dmem_off[`DMEM_MSB:0] : eu_dmem_off[`DMEM_MSB:0];
  assign dmem_din  = dbg_dmem_sel ? dbg_req.dout : eu_req.dout;
  // Masks of both masters merged, each only when it hits RAM
  assign dmem_wen  = ~((dbg_dmem_sel ? dbg_req.wr : 2'b00) |
                       (eu_dmem_sel  ? eu_req.wr  : 2'b00));

  // ==========================================================
  // ROM decode, debug > EU > frontend
  // ==========================================================
  assign eu_pmem_sel  = eu_req.en & ~|eu_req.wr & (eu_req.mab >= PMEM_WBASE);
  assign fe_pmem_sel  = fe_req.en & (fe_req.mab >= PMEM_WBASE);
  assign dbg_pmem_sel = dbg_req.en & (dbg_wadr >= PMEM_WBASE);
  assign eu_pmem_off  = eu_req.mab - PMEM_WBASE;
  assign fe_pmem_off  = fe_req.mab - PMEM_WBASE;
  assign dbg_pmem_off = dbg_wadr - PMEM_WBASE;

  assign pmem_cen  = ~(dbg_pmem_sel | eu_pmem_sel | fe_pmem_sel);
  assign pmem_addr = dbg_pmem_sel ? dbg_pmem_off[`PMEM_MSB:0] :
                     eu_pmem_sel  ? eu_pmem_off[`PMEM_MSB:0]  :
                                    fe_pmem_off[`PMEM_MSB:0];
  assign pmem_wen  = ~(dbg_pmem_sel ? dbg_req.wr : 2'b00);  // Debug is sole writer
  assign pmem_din  = dbg_req.dout;

  assign fe_pmem_wait = fe_pmem_sel & eu_pmem_sel;           // EU steals ROM port

  // ==========================================================
  // Peripheral decode, low 512 bytes
  // ==========================================================
  assign dbg_per_sel = dbg_req.en & (dbg_req.addr[15:9] == 7'h00);
  assign eu_per_sel  = eu_req.en & (eu_req.mab[14:8] == 7'h00);

  assign per_req = '{
    en:   dbg_per_sel | eu_per_sel,
    wen:  dbg_per_sel ? dbg_req.wr    : eu_req.wr,
    addr: dbg_per_sel ? dbg_wadr[7:0] : eu_req.mab[7:0],
    din:  dbg_per_sel ? dbg_req.dout  : eu_req.dout
  };

  // Align peripheral data with memory latency
  always_ff @(posedge mclk) begin
    per_dout_q <= per_dout;
  end

  // ==========================================================
  // Read data return
  // ==========================================================
  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      eu_src_q  <= SRC_DMEM;
      dbg_src_q <= SRC_DMEM;
    end else begin
      eu_src_q  <= eu_pmem_sel  ? SRC_PMEM : eu_per_sel  ? SRC_PER : SRC_DMEM;
      dbg_src_q <= dbg_pmem_sel ? SRC_PMEM : dbg_per_sel ? SRC_PER : SRC_DMEM;
    end
  end

  always_comb begin
    case (eu_src_q)
      SRC_PMEM: eu_mdb_in = pmem_dout;
      SRC_PER:  eu_mdb_in = per_dout_q;
      default:  eu_mdb_in = dmem_dout;  // Unmapped falls here too
    endcase
  end

  always_comb begin
    case (dbg_src_q)
      SRC_PMEM: dbg_mem_din = pmem_dout;
      SRC_PER:  dbg_mem_din = per_dout_q;
      default:  dbg_mem_din = dmem_dout;
    endcase
  end

  // ==========================================================
  // Frontend backup of last fetched word
  // ==========================================================
  // Save on first idle cycle, ROM output still holds the fetch
  assign fe_save    = ~fe_pmem_sel & fe_pmem_sel_q & ~dbg_halt_st;
  assign fe_restore = (fe_pmem_sel & ~fe_pmem_sel_q) | dbg_halt_st;

  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      fe_pmem_sel_q <= 1'b0;
      pmem_bckup_q  <= '0;
      bckup_sel_q   <= 1'b0;
    end else begin
      fe_pmem_sel_q <= fe_pmem_sel;
      if (fe_save) pmem_bckup_q <= pmem_dout;
      if (fe_save) bckup_sel_q <= 1'b1;
      else if (fe_restore) bckup_sel_q <= 1'b0;  // Fetch resumed or halted
    end
  end

  assign fe_mdb_in = bckup_sel_q ? pmem_bckup_q : pmem_dout;

endmodule

/* mem_subsys.sv */
`include "msp_mem_macros.svh"

module mem_subsys (
  input  logic                  mclk,          // Main clock
  input  logic                  puc,           // System reset
  input  msp_mem_pkg::eu_req_t  eu_req,        // Execution unit access
  input  msp_mem_pkg::fe_req_t  fe_req,        // Instruction fetch
  input  msp_mem_pkg::dbg_req_t dbg_req,       // Debug unit access
  input  logic                  dbg_halt_st,   // CPU halted by debug
  output msp_mem_pkg::word_t    eu_mdb_in,     // EU read data
  output msp_mem_pkg::word_t    fe_mdb_in,     // Fetched word
  output msp_mem_pkg::word_t    dbg_mem_din,   // Debug read data
  output logic                  fe_pmem_wait   // Fetch stall
);
  import msp_mem_pkg::*;

  // ROM port
  logic               pmem_cen;
  bwe_t               pmem_wen;
  logic [`PMEM_MSB:0] pmem_addr;
  word_t              pmem_din;
  word_t              pmem_dout;
  // RAM port
  logic               dmem_cen;
  bwe_t               dmem_wen;
  logic [`DMEM_MSB:0] dmem_addr;
  word_t              dmem_din;
  word_t              dmem_dout;
  // Peripheral bus
  per_req_t           per_req;
  word_t              per_dout;

  mem_backbone u_backbone (
    .mclk         (mclk),
    .puc          (puc),
    .eu_req       (eu_req),
    .fe_req       (fe_req),
    .dbg_req      (dbg_req),
    .dbg_halt_st  (dbg_halt_st),
    .pmem_dout    (pmem_dout),
    .dmem_dout    (dmem_dout),
    .per_dout     (per_dout),
    .eu_mdb_in    (eu_mdb_in),
    .fe_mdb_in    (fe_mdb_in),
    .dbg_mem_din  (dbg_mem_din),
    .fe_pmem_wait (fe_pmem_wait),
    .pmem_cen     (pmem_cen),
    .pmem_wen     (pmem_wen),
    .pmem_addr    (pmem_addr),
    .pmem_din     (pmem_din),
    .dmem_cen     (dmem_cen),
    .dmem_wen     (dmem_wen),
    .dmem_addr    (dmem_addr),
    .dmem_din     (dmem_din),
    .per_req      (per_req)
  );

  pmem_rom u_pmem (
    .mclk (mclk),
    .cen  (pmem_cen),
    .wen  (pmem_wen),
    .addr (pmem_addr),
    .din  (pmem_din),
    .dout (pmem_dout)
  );

  dmem_ram u_dmem (
    .mclk (mclk),
    .cen  (dmem_cen),
    .wen  (dmem_wen),
    .addr (dmem_addr),
    .din  (dmem_din),
    .dout (dmem_dout)
  );

  per_regs u_per_regs (
    .mclk     (mclk),
    .puc      (puc),
    .per_req  (per_req),
    .per_dout (per_dout)
  );

endmodule

/* tb_mem_subsys.sv */
module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import msp_mem_pkg::*;

  localparam int RST_CYCLES = 8;     // Reset length in clocks
  localparam int MAX_VEC    = 64;    // Room in the vector memory
  localparam int VEC_FIELDS = 8;     // Words per vector line

  logic     mclk;
  logic     puc;
  eu_req_t  eu_req;
  fe_req_t  fe_req;
  dbg_req_t dbg_req;
  logic     dbg_halt_st;
  word_t    eu_mdb_in;
  word_t    fe_mdb_in;
  word_t    dbg_mem_din;
  logic     fe_pmem_wait;

  word_t vec_mem [MAX_VEC*VEC_FIELDS];  // Raw vector words
  int    num_vec;                       // Vectors before end marker
  int    cycle_cnt   = 0;
  int    cycle_limit = 1000000;         // Replaced once vectors are counted

  mem_subsys UUT (
    .mclk         (mclk),
    .puc          (puc),
    .eu_req       (eu_req),
    .fe_req       (fe_req),
    .dbg_req      (dbg_req),
    .dbg_halt_st  (dbg_halt_st),
    .eu_mdb_in    (eu_mdb_in),
    .fe_mdb_in    (fe_mdb_in),
    .dbg_mem_din  (dbg_mem_din),
    .fe_pmem_wait (fe_pmem_wait)
  );

  initial begin
    mclk = 1'b0;
    forever #2 mclk = ~mclk;         // 4 ns period
  end

  // Run length guard
  always @(posedge mclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, vectors did not complete", cycle_cnt);
      $display("Simulation failed");
      $fatal(1, "Run stopped by cycle limit");
    end
  end

  // ==========================================================
  // Helpers
  // ==========================================================
  function automatic word_t vec_field(input int idx, input int pos);
    return vec_mem[idx*VEC_FIELDS + pos];
  endfunction

  task automatic check_value(input string sig_name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%h, expected 0x%h", sig_name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Compare mismatch");
    end
  endtask

  task automatic drive_vector(input int idx);
    word_t master;
    word_t addr;
    word_t mask;
    word_t data;
    word_t halt;
    master = vec_field(idx, 0);
    addr   = vec_field(idx, 1);
    mask   = vec_field(idx, 2);
    data   = vec_field(idx, 3);
    halt   = vec_field(idx, 4);
    dbg_halt_st <= halt[0];          // Held until next vector
    case (master[3:0])
      4'h0: begin                    // Execution unit
        eu_req.en   <= 1'b1;
        eu_req.wr   <= mask[1:0];
        eu_req.mab  <= addr[15:1];
        eu_req.dout <= data;
      end
      4'h1: begin                    // Frontend fetch
        fe_req.en  <= 1'b1;
        fe_req.mab <= addr[15:1];
      end
      4'h2: begin                    // Debug unit
        dbg_req.en   <= 1'b1;
        dbg_req.wr   <= mask[1:0];
        dbg_req.addr <= addr;
        dbg_req.dout <= data;
      end
      4'h3: begin                    // EU read and fetch together, fetch addr in data
        eu_req.en  <= 1'b1;
        eu_req.wr  <= 2'b00;
        eu_req.mab <= addr[15:1];
        fe_req.en  <= 1'b1;
        fe_req.mab <= data[15:1];
      end
      default: ;                     // Observe fe_mdb_in only
    endcase
  endtask

  task automatic clear_requests();
    eu_req.en  <= 1'b0;
    eu_req.wr  <= 2'b00;
    fe_req.en  <= 1'b0;
    dbg_req.en <= 1'b0;
    dbg_req.wr <= 2'b00;
  endtask

  task automatic check_return(input int idx);
    word_t master;
    word_t expected;
    master   = vec_field(idx, 0);
    expected = vec_field(idx, 5);
    case (master[3:0])
      4'h0, 4'h3: check_value("eu_mdb_in", eu_mdb_in, expected);
      4'h1, 4'h4: check_value("fe_mdb_in", fe_mdb_in, expected);
      default:    check_value("dbg_mem_din", dbg_mem_din, expected);
    endcase
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    eu_req      <= '0;
    fe_req      <= '0;
    dbg_req     <= '0;
    dbg_halt_st <= 1'b0;
    puc         <= 1'b1;
    $readmemh("mem_tests.hex", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_field(num_vec, 0) !== 16'h000F) begin
      num_vec++;
    end
    cycle_limit = 2*num_vec + RST_CYCLES + 20;  // Two clocks per vector
    repeat (RST_CYCLES) @(posedge mclk);
    puc <= 1'b0;
    for (int vi = 0; vi < num_vec; vi++) begin
      @(posedge mclk);
      drive_vector(vi);
      @(negedge mclk);                // Request cycle, wait is combinational
      check_value("fe_pmem_wait", {15'd0, fe_pmem_wait}, vec_field(vi, 6));
      @(posedge mclk);
      clear_requests();
      @(negedge mclk);                // Read data one cycle later
      if (vec_field(vi, 7) != 16'h0000) begin
        check_return(vi);
      end
    end
    @(posedge mclk);
    if (num_vec == 0) begin
      $display("No test vectors found in mem_tests.hex");
      $display("Simulation failed");
      $fatal(1, "Empty vector file");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

/* mem_tests.hex */
// master(0 eu,1 fe,2 dbg,3 eu+fe,4 observe fe,F end) byte_addr wmask wdata(fe addr for 3)
// dbg_halt_st expected_rdata expected_wait check
2 F800 3 1234 0 0000 0 0
2 F802 3 ABCD 0 0000 0 0
2 F804 3 5A5A 0 0000 0 0
2 FFFE 3 C0DE 0 0000 0 0
2 F800 0 0000 0 1234 0 1
0 F804 3 FFFF 0 0000 0 0
0 F804 0 0000 0 5A5A 0 1
1 FFFE 0 0000 0 C0DE 0 1
1 F800 0 0000 0 1234 0 1
0 0200 3 1111 0 0000 0 0
0 0200 0 0000 0 1111 0 1
0 0200 2 AB00 0 0000 0 0
0 0200 1 00CD 0 0000 0 0
0 0200 0 0000 0 ABCD 0 1
2 0202 3 2468 0 0000 0 0
2 0202 0 0000 0 2468 0 1
0 0010 3 A5A5 0 0000 0 0
2 0012 3 1357 0 0000 0 0
0 0012 1 00EE 0 0000 0 0
2 001E 2 7700 0 0000 0 0
2 0010 0 0000 0 A5A5 0 1
0 0012 0 0000 0 13EE 0 1
0 001E 0 0000 0 7700 0 1
2 0020 0 0000 0 0000 0 1
3 F804 0 F800 0 5A5A 1 1
1 F802 0 0000 0 ABCD 0 1
1 FFFE 0 0000 0 C0DE 0 1
0 0200 0 0000 0 ABCD 0 1
4 0000 0 0000 0 C0DE 0 1
0 F800 0 0000 0 1234 0 1
4 0000 0 0000 0 C0DE 0 1
1 F804 0 0000 0 5A5A 0 1
2 FFFE 0 0000 1 C0DE 0 1
4 0000 0 0000 1 C0DE 0 1
F 0000 0 0000 0 0000 0 0

/* list.f */
+incdir+.
msp_mem_pkg.sv
per_regs.sv
pmem_rom.sv
dmem_ram.sv
mem_backbone.sv
mem_subsys.sv
tb_mem_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
